//--- flist.f
+incdir+include
source/menuDisplayPkg.sv
source/scanCounter.sv
source/playButtonSprite.sv
source/lineBuffer.sv
source/pixelColorizer.sv
source/menuDisplay.sv
sim/menuDisplayTb.sv

//--- include/menuDisplay_cfg.svh
`ifndef MENU_DISPLAY_CFG_SVH
`define MENU_DISPLAY_CFG_SVH

// visible area in pixels
`define SCREEN_WIDTH 320
`define SCREEN_HEIGHT 240

// top left corner of the play button sprite
`define BUTTON_X 125
`define BUTTON_Y 90

`define FG_COLOR 12'hFFF // lit sprite pixels
`define BG_COLOR 12'h013 // everything else

`endif

//--- sim/menuDisplayTb.sv
`timescale 1ns/1ns
`include "menuDisplay_cfg.svh"

module menuDisplayTb;

  localparam int FRAME_PIXELS = `SCREEN_WIDTH * `SCREEN_HEIGHT;
  localparam int WAIT_LIMIT = 90000;
  localparam int RUN_LEN = 24; // cycles per pacing run

  logic                       clk;
  logic                       rstN;
  logic                       pixelEn;
  logic                       menuVisible;
  menuDisplayPkg::pixelColorT outColor;
  menuDisplayPkg::pixelXT     outX;
  menuDisplayPkg::pixelYT     outY;
  logic                       outValid;
  logic                       outLineStart;
  logic                       outFrameStart;

  // stimulus and expected values, one entry per test, in scan order
  string                      names[$];
  menuDisplayPkg::pixelXT     tabX[$];
  menuDisplayPkg::pixelYT     tabY[$];
  logic                       tabVis[$];
  menuDisplayPkg::pixelColorT tabColor[$];

  logic [31:0]            lfsrState;
  int                     issued; // pixelEn strobes driven so far
  int                     outCount;
  int                     frameGrant; // last frame the driver may start
  int                     runCycle;
  int                     runIdx;
  int                     hist[4];
  menuDisplayPkg::pixelXT expX;
  menuDisplayPkg::pixelYT expY;
  int                     orderErrors;
  int                     countErrors;
  int                     resetErrors;
  int                     passCount;
  int                     failCount;
  bit                     timedOut;

  menuDisplay menuDisplay_i (
    .clk           (clk),
    .rstN          (rstN),
    .pixelEn       (pixelEn),
    .menuVisible   (menuVisible),
    .outColor      (outColor),
    .outX          (outX),
    .outY          (outY),
    .outValid      (outValid),
    .outLineStart  (outLineStart),
    .outFrameStart (outFrameStart)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic checkColor(input string name, input menuDisplayPkg::pixelColorT expV,
                            input menuDisplayPkg::pixelColorT actV, output bit ok);
    ok = (expV === actV);
    if (!ok) $display("** Error: %s: expected %h, actual %h", name, expV, actV);
  endtask

  task automatic checkCoord(input string name, input menuDisplayPkg::pixelXT expXV,
                            input menuDisplayPkg::pixelYT expYV,
                            input menuDisplayPkg::pixelXT actXV,
                            input menuDisplayPkg::pixelYT actYV, output bit ok);
    ok = (expXV === actXV) && (expYV === actYV);
    if (!ok) begin
      $display("** Error: %s: expected (%0d,%0d), actual (%0d,%0d)",
               name, expXV, expYV, actXV, actYV);
    end
  endtask

  task automatic checkFlags(input string name, input logic expLine, input logic expFrame,
                            input logic actLine, input logic actFrame, output bit ok);
    ok = (expLine === actLine) && (expFrame === actFrame);
    if (!ok) begin
      $display("** Error: %s: expected line/frame %b%b, actual %b%b",
               name, expLine, expFrame, actLine, actFrame);
    end
  endtask

  task automatic addEntry(input string name, input int x, input int y, input logic vis,
                          input menuDisplayPkg::pixelColorT color);
    names.push_back(name);
    tabX.push_back(9'(x));
    tabY.push_back(8'(y));
    tabVis.push_back(vis);
    tabColor.push_back(color);
  endtask

  task automatic reportTest(input string name, input bit ok);
    if (ok) begin
      passCount++;
      $display("test %s: passed", name);
    end else begin
      failCount++;
      $display("test %s: failed", name);
    end
  endtask

  // output monitor first, then the pixelEn driver, all on the falling edge
  always @(negedge clk) begin : monitorAndDrive
    bit ok;
    bit takeEn;
    if (!rstN) begin
      if (outValid !== 1'b0) begin
        if (resetErrors == 0) $display("outValid was not low during reset");
        resetErrors++;
      end
    end else begin
      if (outValid) begin
        checkCoord("scan order", expX, expY, outX, outY, ok);
        if (!ok) begin
          orderErrors++;
          expX = outX; // resync to avoid a flood of errors
          expY = outY;
        end
        checkFlags("start flags", expX == 0, (expX == 0) && (expY == 0),
                   outLineStart, outFrameStart, ok);
        if (!ok) orderErrors++;
        outCount++;
        if (expX == `SCREEN_WIDTH - 1) begin
          expX = '0;
          expY = (expY == `SCREEN_HEIGHT - 1) ? '0 : expY + 8'd1;
        end else begin
          expX = expX + 9'd1;
        end
      end
      if (outCount != hist[3]) begin
        if (countErrors == 0) begin
          $display("pixel count mismatch: %0d outputs seen, %0d pixels issued 4 cycles earlier",
                   outCount, hist[3]);
        end
        countErrors++;
      end
      takeEn = 1'b0;
      if (issued / FRAME_PIXELS <= frameGrant) begin // hold at a frame the loop has not opened
        if (runIdx % 3 == 2) begin
          takeEn = 1'b1;
        end else begin
          lfsrState = lfsrStep(lfsrState);
          takeEn = lfsrState[0];
        end
        runCycle++;
        if (runCycle == RUN_LEN) begin
          runCycle = 0;
          runIdx++;
        end
      end
      pixelEn = takeEn;
      if (takeEn) issued++;
    end
    hist[3] = hist[2];
    hist[2] = hist[1];
    hist[1] = hist[0];
    hist[0] = issued;
  end

  initial begin
    int  prevPos;
    int  pos;
    int  curFrame;
    int  waitCnt;
    bit  ok;
    bit  found;
    clk = 1'b0;
    rstN = 1'b0;
    pixelEn = 1'b0;
    lfsrState = 32'h42cc86fe;
    issued = 0;
    outCount = 0;
    frameGrant = 0;
    runCycle = 0;
    runIdx = 0;
    hist = '{0, 0, 0, 0};
    expX = '0;
    expY = '0;
    orderErrors = 0;
    countErrors = 0;
    resetErrors = 0;
    passCount = 0;
    failCount = 0;
    timedOut = 1'b0;

    // output (X, Y) shows sprite cell (X - 125, Y - 91)
    addEntry("row above sprite", 155, 90, 1'b1, `BG_COLOR);
    addEntry("caption lit", 134, 91, 1'b1, `FG_COLOR);
    addEntry("left of origin", 124, 131, 1'b1, `BG_COLOR);
    addEntry("button body", 155, 131, 1'b1, `FG_COLOR);
    addEntry("triangle cut-out", 160, 141, 1'b1, `BG_COLOR);
    addEntry("button left edge", 125, 143, 1'b1, `FG_COLOR);
    addEntry("visible last pixel", 319, 239, 1'b1, `BG_COLOR);
    addEntry("hidden first pixel", 0, 0, 1'b0, `BG_COLOR);
    addEntry("hidden caption", 134, 91, 1'b0, `BG_COLOR);
    addEntry("hidden button body", 155, 131, 1'b0, `BG_COLOR);
    addEntry("hidden last pixel", 319, 239, 1'b0, `BG_COLOR);
    addEntry("shown first pixel", 0, 0, 1'b1, `BG_COLOR);
    addEntry("shown button body", 155, 131, 1'b1, `FG_COLOR);
    menuVisible = tabVis[0];

    repeat (4) @(negedge clk);
    rstN = 1'b1;

    prevPos = -1;
    curFrame = 0;
    for (int i = 0; i < names.size() && !timedOut; i++) begin
      pos = int'(tabY[i]) * `SCREEN_WIDTH + int'(tabX[i]);
      if (pos <= prevPos) begin
        // new frame: let the pipeline drain, then switch visibility
        curFrame++;
        waitCnt = 0;
        while (!(issued == curFrame * FRAME_PIXELS && outCount == issued)
               && waitCnt < WAIT_LIMIT) begin
          @(posedge clk);
          waitCnt++;
        end
        if (waitCnt == WAIT_LIMIT) begin
          $display("timed out waiting for the end of frame %0d", curFrame - 1);
          timedOut = 1'b1;
        end else begin
          @(negedge clk);
          menuVisible = tabVis[i];
          frameGrant = curFrame;
        end
      end
      prevPos = pos;
      if (!timedOut) begin
        found = 1'b0;
        waitCnt = 0;
        while (!found && waitCnt < WAIT_LIMIT) begin
          @(negedge clk);
          waitCnt++;
          found = outValid && (outX == tabX[i]) && (outY == tabY[i]);
        end
        if (!found) begin
          $display("timed out waiting for pixel");
          timedOut = 1'b1;
          reportTest(names[i], 1'b0);
        end else begin
          checkColor(names[i], tabColor[i], outColor, ok);
          reportTest(names[i], ok);
        end
      end
    end

    reportTest("quiet reset", resetErrors == 0);
    reportTest("raster order and flags", orderErrors == 0);
    reportTest("pixel count", countErrors == 0);
    $display("tests passed: %0d, failed: %0d", passCount, failCount);
    if (timedOut || failCount != 0) begin
      $display("=== FAIL ===");
    end else begin
      $display("=== PASS ===");
    end
    $finish;
  end

endmodule

//--- source/lineBuffer.sv
`timescale 1ns/1ns
`include "menuDisplay_cfg.svh"

module lineBuffer (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   spriteBit,
  input  logic                   spriteEn,
  input  logic                   spriteLineStart,
  input  logic                   spriteFrameStart,
  input  menuDisplayPkg::pixelXT spriteX,
  input  menuDisplayPkg::pixelYT spriteY,
  output logic                   bufBit,
  output logic                   bufEn,
  output logic                   bufLineStart,
  output logic                   bufFrameStart,
  output menuDisplayPkg::pixelXT bufX,
  output menuDisplayPkg::pixelYT bufY
);

  logic [1:0][`SCREEN_WIDTH-1:0] lineMem; // ping-pong halves, one per row parity
  logic                          wrHalf;
  logic                          rdHalf;
  logic                          lastWrHalf;

  assign wrHalf = spriteY[0];
  assign rdHalf = ~spriteY[0]; // holds the previous row

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      lineMem       <= '0;
      lastWrHalf    <= 1'b0;
      bufEn         <= 1'b0;
      bufLineStart  <= 1'b0;
      bufFrameStart <= 1'b0;
    end else begin
      bufEn         <= spriteEn;
      bufLineStart  <= spriteLineStart;
      bufFrameStart <= spriteFrameStart;
      if (spriteEn) begin
        lineMem[wrHalf][spriteX] <= spriteBit;
        lastWrHalf               <= wrHalf;
      end
    end
  end

  // read of the other half, same column
  always_ff @(posedge clk) begin
    if (spriteEn) begin
      bufBit <= lineMem[rdHalf][spriteX];
      bufX   <= spriteX;
      bufY   <= spriteY;
    end
  end

  // write half only flips at a line start
  halfSplitA: assert property (
    @(posedge clk) disable iff (!rstN)
    spriteEn |-> (spriteLineStart || (wrHalf == lastWrHalf))
  ) else $error("line buffer read and write hit the same half");

endmodule

//--- source/menuDisplay.sv
`timescale 1ns/1ns

module menuDisplay (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       pixelEn,
  input  logic                       menuVisible,
  output menuDisplayPkg::pixelColorT outColor,
  output menuDisplayPkg::pixelXT     outX,
  output menuDisplayPkg::pixelYT     outY,
  output logic                       outValid,
  output logic                       outLineStart,
  output logic                       outFrameStart
);

  // scan stage
  menuDisplayPkg::pixelXT scanX;
  menuDisplayPkg::pixelYT scanY;
  logic                   scanEn;
  logic                   scanLineStart;
  logic                   scanFrameStart;

  // sprite stage
  menuDisplayPkg::pixelXT spriteX;
  menuDisplayPkg::pixelYT spriteY;
  logic                   spriteBit;
  logic                   spriteEn;
  logic                   spriteLineStart;
  logic                   spriteFrameStart;

  // line buffer stage, one row behind
  menuDisplayPkg::pixelXT bufX;
  menuDisplayPkg::pixelYT bufY;
  logic                   bufBit;
  logic                   bufEn;
  logic                   bufLineStart;
  logic                   bufFrameStart;

  scanCounter scanCounter_i (
    .clk            (clk),
    .rstN           (rstN),
    .pixelEn        (pixelEn),
    .scanX          (scanX),
    .scanY          (scanY),
    .scanEn         (scanEn),
    .scanLineStart  (scanLineStart),
    .scanFrameStart (scanFrameStart)
  );

  playButtonSprite playButtonSprite_i (
    .clk              (clk),
    .rstN             (rstN),
    .scanX            (scanX),
    .scanY            (scanY),
    .scanEn           (scanEn),
    .scanLineStart    (scanLineStart),
    .scanFrameStart   (scanFrameStart),
    .menuVisible      (menuVisible),
    .spriteBit        (spriteBit),
    .spriteEn         (spriteEn),
    .spriteLineStart  (spriteLineStart),
    .spriteFrameStart (spriteFrameStart),
    .spriteX          (spriteX),
    .spriteY          (spriteY)
  );

  lineBuffer lineBuffer_i (
    .clk              (clk),
    .rstN             (rstN),
    .spriteBit        (spriteBit),
    .spriteEn         (spriteEn),
    .spriteLineStart  (spriteLineStart),
    .spriteFrameStart (spriteFrameStart),
    .spriteX          (spriteX),
    .spriteY          (spriteY),
    .bufBit           (bufBit),
    .bufEn            (bufEn),
    .bufLineStart     (bufLineStart),
    .bufFrameStart    (bufFrameStart),
    .bufX             (bufX),
    .bufY             (bufY)
  );

  pixelColorizer pixelColorizer_i (
    .clk           (clk),
    .rstN          (rstN),
    .bufBit        (bufBit),
    .bufEn         (bufEn),
    .bufLineStart  (bufLineStart),
    .bufFrameStart (bufFrameStart),
    .bufX          (bufX),
    .bufY          (bufY),
    .outColor      (outColor),
    .outX          (outX),
    .outY          (outY),
    .outValid      (outValid),
    .outLineStart  (outLineStart),
    .outFrameStart (outFrameStart)
  );

endmodule

//--- source/menuDisplayPkg.sv
package menuDisplayPkg;

  // column index, 0 to 319
  typedef logic [8:0] pixelXT;

  // row index, 0 to 239
  typedef logic [7:0] pixelYT;

  // rgb444: red [11:8], green [7:4], blue [3:0]
  typedef logic [11:0] pixelColorT;

endpackage

//--- source/pixelColorizer.sv
`timescale 1ns/1ns
`include "menuDisplay_cfg.svh"

module pixelColorizer (
  input  logic                       clk,
  input  logic                       rstN,
  input  logic                       bufBit,
  input  logic                       bufEn,
  input  logic                       bufLineStart,
  input  logic                       bufFrameStart,
  input  menuDisplayPkg::pixelXT     bufX,
  input  menuDisplayPkg::pixelYT     bufY,
  output menuDisplayPkg::pixelColorT outColor,
  output menuDisplayPkg::pixelXT     outX,
  output menuDisplayPkg::pixelYT     outY,
  output logic                       outValid,
  output logic                       outLineStart,
  output logic                       outFrameStart
);

  menuDisplayPkg::pixelColorT pixColor;

  assign pixColor = bufBit ? `FG_COLOR : `BG_COLOR;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outValid      <= 1'b0;
      outLineStart  <= 1'b0;
      outFrameStart <= 1'b0;
    end else begin
      outValid      <= bufEn;
      outLineStart  <= bufEn && bufLineStart; // flags only ride along with a pixel
      outFrameStart <= bufEn && bufFrameStart;
    end
  end

  always_ff @(posedge clk) begin
    if (bufEn) begin
      outColor <= pixColor;
      outX     <= bufX;
      outY     <= bufY;
    end
  end

endmodule

//--- source/playButtonSprite.sv
`timescale 1ns/1ns
`include "menuDisplay_cfg.svh"

module playButtonSprite (
  input  logic                   clk,
  input  logic                   rstN,
  input  menuDisplayPkg::pixelXT scanX,
  input  menuDisplayPkg::pixelYT scanY,
  input  logic                   scanEn,
  input  logic                   scanLineStart,
  input  logic                   scanFrameStart,
  input  logic                   menuVisible,
  output logic                   spriteBit,
  output logic                   spriteEn,
  output logic                   spriteLineStart,
  output logic                   spriteFrameStart,
  output menuDisplayPkg::pixelXT spriteX,
  output menuDisplayPkg::pixelYT spriteY
);

  menuDisplayPkg::pixelXT relX;
  menuDisplayPkg::pixelYT relY;
  logic                   hit;

  // positions left of or above the origin wrap to large values and never hit
  assign relX = scanX - 9'(`BUTTON_X);
  assign relY = scanY - 8'(`BUTTON_Y);

  function automatic logic span(input menuDisplayPkg::pixelXT v, input int lo, input int hi);
    return (v >= lo) && (v <= hi);
  endfunction

  always_comb begin
    hit = 1'b0;
    case (relY)
      // caption "play", rows 0 to 29
      8'd0:  hit = span(relX, 9, 12) || span(relX, 53, 53);
      8'd1:  hit = span(relX, 8, 13) || span(relX, 53, 53);
      8'd2:  hit = span(relX, 7, 9) || span(relX, 12, 14) || span(relX, 53, 54);
      8'd3:  hit = span(relX, 6, 8) || span(relX, 13, 15) || span(relX, 53, 54);
      8'd4:  hit = span(relX, 6, 7) || span(relX, 14, 15) || span(relX, 53, 54);
      8'd5, 8'd6:
        hit = span(relX, 6, 7) || span(relX, 15, 15) || span(relX, 53, 54);
      8'd7, 8'd8, 8'd9:
        hit = span(relX, 6, 7) || span(relX, 53, 54);
      8'd10: hit = span(relX, 6, 7) || span(relX, 9, 12) || span(relX, 53, 54);
      8'd11: hit = span(relX, 6, 13) || span(relX, 21, 22) || span(relX, 24, 28)
                || span(relX, 36, 38) || span(relX, 48, 54);
      8'd12: hit = span(relX, 6, 9) || span(relX, 12, 14) || span(relX, 22, 29)
                || span(relX, 37, 39) || span(relX, 47, 54);
      8'd13: hit = span(relX, 6, 8) || span(relX, 13, 15) || span(relX, 22, 25)
                || span(relX, 28, 30) || span(relX, 38, 39) || span(relX, 46, 48)
                || span(relX, 52, 54);
      8'd14: hit = span(relX, 6, 7) || span(relX, 14, 15) || span(relX, 22, 23)
                || span(relX, 29, 30) || span(relX, 38, 39) || span(relX, 45, 47)
                || span(relX, 53, 54);
      8'd15: hit = span(relX, 6, 7) || span(relX, 14, 15) || span(relX, 22, 23)
                || span(relX, 28, 30) || span(relX, 38, 39) || span(relX, 45, 46)
                || span(relX, 53, 54);
      8'd16: hit = span(relX, 6, 7) || span(relX, 14, 15) || span(relX, 22, 24)
                || span(relX, 27, 29) || span(relX, 38, 39) || span(relX, 45, 46)
                || span(relX, 53, 54);
      8'd17: hit = span(relX, 6, 7) || span(relX, 14, 15) || span(relX, 22, 28)
                || span(relX, 38, 39) || span(relX, 45, 46) || span(relX, 53, 54);
      8'd18: hit = span(relX, 6, 7) || span(relX, 14, 15) || span(relX, 22, 23)
                || span(relX, 25, 27) || span(relX, 38, 39) || span(relX, 45, 46)
                || span(relX, 53, 54);
      8'd19: hit = span(relX, 6, 7) || span(relX, 14, 15) || span(relX, 22, 23)
                || span(relX, 30, 30) || span(relX, 38, 39) || span(relX, 45, 47)
                || span(relX, 53, 54);
      8'd20: hit = span(relX, 6, 7) || span(relX, 14, 15) || span(relX, 22, 24)
                || span(relX, 29, 30) || span(relX, 38, 39) || span(relX, 46, 48)
                || span(relX, 52, 54);
      8'd21: hit = span(relX, 7, 7) || span(relX, 14, 14) || span(relX, 23, 29)
                || span(relX, 38, 39) || span(relX, 47, 53);
      8'd22: hit = span(relX, 7, 7) || span(relX, 14, 14) || span(relX, 25, 28)
                || span(relX, 38, 39) || span(relX, 48, 52);
      8'd23, 8'd24, 8'd25, 8'd26, 8'd27:
        hit = span(relX, 38, 39); // tail of the y
      8'd28, 8'd29:
        hit = span(relX, 38, 38);

      // round button, rows 35 to 69
      8'd35: hit = span(relX, 18, 42);
      8'd36: hit = span(relX, 11, 50);
      8'd37: hit = span(relX, 6, 54);
      8'd38: hit = span(relX, 3, 57);
      8'd39: hit = span(relX, 2, 58);
      8'd40, 8'd41, 8'd42:
        hit = span(relX, 1, 59);
      // triangle cut-out between the left part and the right part
      8'd43: hit = span(relX, 0, 33) || span(relX, 38, 60);
      8'd44: hit = span(relX, 0, 31) || span(relX, 39, 60);
      8'd45: hit = span(relX, 0, 29) || span(relX, 39, 60);
      8'd46: hit = span(relX, 0, 27) || span(relX, 39, 60);
      8'd47: hit = span(relX, 0, 25) || span(relX, 39, 60);
      8'd48: hit = span(relX, 0, 23) || span(relX, 39, 60);
      8'd49: hit = span(relX, 0, 21) || span(relX, 39, 60);
      8'd50: hit = span(relX, 0, 20) || span(relX, 39, 60);
      8'd51, 8'd52, 8'd53:
        hit = span(relX, 0, 19) || span(relX, 39, 60); // tip of the triangle
      8'd54: hit = span(relX, 0, 20) || span(relX, 39, 60);
      8'd55: hit = span(relX, 0, 21) || span(relX, 39, 60);
      8'd56: hit = span(relX, 0, 23) || span(relX, 39, 60);
      8'd57: hit = span(relX, 0, 25) || span(relX, 39, 60);
      8'd58: hit = span(relX, 0, 27) || span(relX, 39, 60);
      8'd59: hit = span(relX, 0, 29) || span(relX, 39, 60);
      8'd60: hit = span(relX, 0, 31) || span(relX, 39, 60);
      8'd61: hit = span(relX, 0, 33) || span(relX, 38, 60);
      8'd62, 8'd63, 8'd64:
        hit = span(relX, 1, 59);
      8'd65: hit = span(relX, 2, 58);
      8'd66: hit = span(relX, 3, 57);
      8'd67: hit = span(relX, 6, 54);
      8'd68: hit = span(relX, 11, 50);
      8'd69: hit = span(relX, 18, 42);
      default: hit = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      spriteBit        <= 1'b0;
      spriteEn         <= 1'b0;
      spriteLineStart  <= 1'b0;
      spriteFrameStart <= 1'b0;
    end else begin
      spriteBit        <= hit && menuVisible;
      spriteEn         <= scanEn;
      spriteLineStart  <= scanLineStart;
      spriteFrameStart <= scanFrameStart;
    end
  end

  always_ff @(posedge clk) begin
    if (scanEn) begin
      spriteX <= scanX;
      spriteY <= scanY;
    end
  end

  hiddenMenuDarkA: assert property (
    @(posedge clk) disable iff (!rstN)
    spriteBit |-> $past(menuVisible)
  ) else $error("sprite bit lit while the menu was hidden");

endmodule

//--- source/scanCounter.sv
`timescale 1ns/1ns
`include "menuDisplay_cfg.svh"

module scanCounter (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   pixelEn,
  output menuDisplayPkg::pixelXT scanX,
  output menuDisplayPkg::pixelYT scanY,
  output logic                   scanEn,
  output logic                   scanLineStart,
  output logic                   scanFrameStart
);

  menuDisplayPkg::pixelXT xCnt; // position of the next pixel to issue
  menuDisplayPkg::pixelYT yCnt;
  logic                   lastCol;
  logic                   lastRow;

  assign lastCol = (xCnt == 9'(`SCREEN_WIDTH - 1));
  assign lastRow = (yCnt == 8'(`SCREEN_HEIGHT - 1));

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      xCnt <= '0;
      yCnt <= '0;
    end else if (pixelEn) begin
      if (lastCol) begin
        xCnt <= '0;
        yCnt <= lastRow ? '0 : yCnt + 8'd1; // wrap to the top after the last row
      end else begin
        xCnt <= xCnt + 9'd1;
      end
    end
  end

  // one register stage: scanEn names the position held in scanX/scanY
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      scanX          <= '0;
      scanY          <= '0;
      scanEn         <= 1'b0;
      scanLineStart  <= 1'b0;
      scanFrameStart <= 1'b0;
    end else begin
      scanEn         <= pixelEn;
      scanLineStart  <= pixelEn && (xCnt == '0);
      scanFrameStart <= pixelEn && (xCnt == '0) && (yCnt == '0);
      if (pixelEn) begin
        scanX <= xCnt;
        scanY <= yCnt;
      end
    end
  end

  scanInScreenA: assert property (
    @(posedge clk) disable iff (!rstN)
    scanEn |-> (scanX < `SCREEN_WIDTH) && (scanY < `SCREEN_HEIGHT)
  ) else $error("scan position outside the screen");

endmodule
